// ==== verilog/feeder_pkg.sv ====
package feeder_pkg;

	localparam int DATA_W    = 16;   // one pixel channel word
	localparam int COL_W     = 6;
	localparam int MAX_COLS  = 32;
	localparam int CHAN_W    = 4;
	localparam int MAX_CHANS = 8;
	localparam int ADDR_W    = 10;   // four rows of 32x8 words
	localparam int ROW_W     = 6;

	// run configuration, sampled on start
	typedef struct packed {
		logic [COL_W-1:0]  cols;
		logic [CHAN_W-1:0] chans;
		logic              stride2;   // 1 = stride 2
	} cfg_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
	} pix_in_t;

	typedef struct packed {
		logic              en;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} wr_req_t;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr;
		logic              pad;    // word lies outside the image
		logic              last;   // final word of the frame
	} rd_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              pad;
	} pix_out_t;

endpackage

// ==== verilog/line_ram.sv ====
module line_ram #(
	parameter int DEPTH = 1024
) (
	input  logic                          clk,
	input  feeder_pkg::wr_req_t           i_wr,
	input  logic [feeder_pkg::ADDR_W-1:0] i_rd_addr,
	output logic [feeder_pkg::DATA_W-1:0] o_rd_data
);
	import feeder_pkg::*;

	logic [DATA_W-1:0] mem [DEPTH];   // ring of row buffers

	always_ff @(posedge clk) begin
		if (i_wr.en) begin
			mem[i_wr.addr] <= i_wr.data;
		end
	end

	// registered read port, data one cycle after the address
	always_ff @(posedge clk) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

// ==== verilog/row_writer.sv ====
module row_writer #(
	parameter int BUF_ROWS = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         i_start,
	input  feeder_pkg::cfg_t             i_cfg,
	input  logic                         i_valid,
	input  feeder_pkg::pix_in_t          i_pix,
	input  logic [feeder_pkg::ROW_W-1:0] i_rows_released,
	output feeder_pkg::wr_req_t          o_wr,
	output logic [feeder_pkg::ROW_W-1:0] o_rows_written,
	output logic                         o_full
);
	import feeder_pkg::*;

	logic              size_load;   // first cycle of a frame, row size not yet valid
	logic [ADDR_W-1:0] row_size;
	logic [ADDR_W-1:0] slot_base;
	logic [ADDR_W-1:0] col_base;
	logic [CHAN_W-1:0] chan_cnt;
	logic [COL_W-1:0]  col_cnt;
	logic [ROW_W-1:0]  row_cnt;
	logic [ROW_W-1:0]  slot;
	logic              rows_done;
	logic              chan_wrap;
	logic              col_wrap;
	logic              accept;

	assign rows_done = (row_cnt == ROW_W'(i_cfg.cols));
	assign chan_wrap = (chan_cnt == i_cfg.chans - CHAN_W'(1));
	assign col_wrap  = (col_cnt == i_cfg.cols - COL_W'(1));

	// ring is full once the next row would land on a slot still in use
	assign o_full = size_load ||
		(!rows_done && (row_cnt == i_rows_released + ROW_W'(BUF_ROWS)));
	assign accept = i_valid && !o_full && !rows_done && !i_start;

	always_comb begin
		o_wr.en   = accept;
		o_wr.addr = slot_base + col_base + ADDR_W'(chan_cnt);
		o_wr.data = i_pix.data;
	end

	assign o_rows_written = row_cnt;

	always_ff @(posedge clk) begin
		if (size_load) begin
			row_size <= ADDR_W'(i_cfg.cols) * ADDR_W'(i_cfg.chans);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			size_load <= 1'b0;
			chan_cnt  <= '0;
			col_cnt   <= '0;
			row_cnt   <= '0;
			slot      <= '0;
			col_base  <= '0;
			slot_base <= '0;
		end else if (i_start) begin
			size_load <= 1'b1;
			chan_cnt  <= '0;
			col_cnt   <= '0;
			row_cnt   <= '0;
			slot      <= '0;
			col_base  <= '0;
			slot_base <= '0;
		end else begin
			size_load <= 1'b0;
			if (accept) begin
				chan_cnt <= chan_wrap ? '0 : chan_cnt + CHAN_W'(1);
				if (chan_wrap && col_wrap) begin
					col_cnt  <= '0;
					col_base <= '0;
					row_cnt  <= row_cnt + ROW_W'(1);   // row complete
					if (slot == ROW_W'(BUF_ROWS - 1)) begin
						slot      <= '0;
						slot_base <= '0;
					end else begin
						slot      <= slot + ROW_W'(1);
						slot_base <= slot_base + row_size;
					end
				end else if (chan_wrap) begin
					col_cnt  <= col_cnt + COL_W'(1);
					col_base <= col_base + ADDR_W'(i_cfg.chans);
				end
			end
		end
	end

endmodule

// ==== verilog/window_reader.sv ====
module window_reader #(
	parameter int BUF_ROWS = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         i_start,
	input  feeder_pkg::cfg_t             i_cfg,
	input  logic [feeder_pkg::ROW_W-1:0] i_rows_written,
	output logic [feeder_pkg::ROW_W-1:0] o_rows_released,
	output feeder_pkg::rd_req_t          o_rd
);
	import feeder_pkg::*;

	localparam int SW = COL_W + 2;   // room for -1 and the top edge, msb is the sign

	logic              run;
	logic [COL_W-1:0]  oy;
	logic [COL_W-1:0]  ox;
	logic [1:0]        ky;
	logic [1:0]        kx;
	logic [CHAN_W-1:0] ch;

	logic [COL_W-1:0]  out_dim;
	logic [COL_W-1:0]  row_base;
	logic [COL_W-1:0]  col_base;
	logic [SW-1:0]     src_row;
	logic [SW-1:0]     src_col;
	logic              row_out;
	logic              col_out;
	logic              pad;
	logic              ready;
	logic              issue;
	logic              ch_wrap;
	logic              kx_wrap;
	logic              ky_wrap;
	logic              ox_wrap;
	logic              oy_wrap;
	logic              last;
	logic [ADDR_W-1:0] row_size;
	logic [ADDR_W-1:0] slot_idx;
	logic [ADDR_W-1:0] col_off;
	logic [ADDR_W-1:0] rd_addr;

	assign out_dim  = i_cfg.stride2 ? COL_W'(((i_cfg.cols - COL_W'(1)) >> 1) + COL_W'(1))
	                                : i_cfg.cols;
	assign row_base = i_cfg.stride2 ? {oy[COL_W-2:0], 1'b0} : oy;
	assign col_base = i_cfg.stride2 ? {ox[COL_W-2:0], 1'b0} : ox;

	// window is centred, so the top-left tap sits one row and column back
	assign src_row = SW'(row_base) + SW'(ky) - SW'(1);
	assign src_col = SW'(col_base) + SW'(kx) - SW'(1);
	assign row_out = src_row[SW-1] || (src_row[SW-2:0] >= (SW-1)'(i_cfg.cols));
	assign col_out = src_col[SW-1] || (src_col[SW-2:0] >= (SW-1)'(i_cfg.cols));
	assign pad     = row_out || col_out;

	// bottom tap row must be written, clipped at the last image row
	always_comb begin
		if (row_base >= i_cfg.cols - COL_W'(1)) begin
			ready = (i_rows_written > ROW_W'(i_cfg.cols - COL_W'(1)));
		end else begin
			ready = (i_rows_written > ROW_W'(row_base + COL_W'(1)));
		end
	end

	// rows above the current window top are free for reuse
	assign o_rows_released = (row_base == '0) ? '0 : ROW_W'(row_base - COL_W'(1));

	assign issue   = run && ready;
	assign ch_wrap = (ch == i_cfg.chans - CHAN_W'(1));
	assign kx_wrap = (kx == 2'd2);
	assign ky_wrap = (ky == 2'd2);
	assign ox_wrap = (ox == out_dim - COL_W'(1));
	assign oy_wrap = (oy == out_dim - COL_W'(1));
	assign last    = ch_wrap && kx_wrap && ky_wrap && ox_wrap && oy_wrap;

	assign row_size = ADDR_W'(i_cfg.cols) * ADDR_W'(i_cfg.chans);
	assign slot_idx = ADDR_W'(src_row[ROW_W-1:0] % BUF_ROWS);   // ring slot of the source row
	assign col_off  = ADDR_W'(src_col[COL_W-1:0]) * ADDR_W'(i_cfg.chans);
	assign rd_addr  = slot_idx * row_size + col_off + ADDR_W'(ch);

	always_comb begin
		o_rd.valid = issue;
		o_rd.addr  = pad ? '0 : rd_addr;
		o_rd.pad   = pad;
		o_rd.last  = last;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
			oy  <= '0;
			ox  <= '0;
			ky  <= '0;
			kx  <= '0;
			ch  <= '0;
		end else if (i_start) begin
			run <= 1'b1;
			oy  <= '0;
			ox  <= '0;
			ky  <= '0;
			kx  <= '0;
			ch  <= '0;
		end else if (issue) begin
			if (last) begin
				run <= 1'b0;   // idle until the next start
			end
			ch <= ch_wrap ? '0 : ch + CHAN_W'(1);
			if (ch_wrap) begin
				kx <= kx_wrap ? 2'd0 : kx + 2'd1;
				if (kx_wrap) begin
					ky <= ky_wrap ? 2'd0 : ky + 2'd1;
					if (ky_wrap) begin
						ox <= ox_wrap ? '0 : ox + COL_W'(1);
						if (ox_wrap && !last) begin
							oy <= oy + COL_W'(1);   // oy holds after the frame so no rows get freed
						end
					end
				end
			end
		end
	end

endmodule

// ==== verilog/pixel_output.sv ====
module pixel_output (
	input  logic                          clk,
	input  logic                          rst,
	input  feeder_pkg::rd_req_t           i_rd,
	input  logic [feeder_pkg::DATA_W-1:0] i_rd_data,
	output logic                          o_valid,
	output feeder_pkg::pix_out_t          o_pix,
	output logic                          o_done
);
	logic valid_q;
	logic last_q;
	logic pad_q;

	// flags follow the request through the one-cycle ram read
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			last_q  <= 1'b0;
		end else begin
			valid_q <= i_rd.valid;
			last_q  <= i_rd.valid && i_rd.last;
		end
	end

	always_ff @(posedge clk) begin
		pad_q <= i_rd.pad;
	end

	assign o_valid = valid_q;
	assign o_done  = last_q;   // lines up with the final word

	always_comb begin
		o_pix.data = pad_q ? '0 : i_rd_data;   // padded taps read as zero
		o_pix.pad  = pad_q;
	end

endmodule

// ==== verilog/feeder_top.sv ====
module feeder_top #(
	parameter int BUF_ROWS = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 i_start,
	input  feeder_pkg::cfg_t     i_cfg,
	input  logic                 i_valid,
	input  feeder_pkg::pix_in_t  i_pix,
	output logic                 o_full,
	output logic                 o_valid,
	output feeder_pkg::pix_out_t o_pix,
	output logic                 o_done
);
	import feeder_pkg::*;

	localparam int FULL_DEPTH = BUF_ROWS * MAX_COLS * MAX_CHANS;
	localparam int DEPTH      = (FULL_DEPTH > 2 ** ADDR_W) ? 2 ** ADDR_W : FULL_DEPTH;

	cfg_t              cfg_q;
	wr_req_t           wr;
	rd_req_t           rd;
	logic [ROW_W-1:0]  rows_written;
	logic [ROW_W-1:0]  rows_released;
	logic [DATA_W-1:0] rd_data;

	// zero cols after reset keeps the writer from accepting anything
	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_q <= '0;
		end else if (i_start) begin
			cfg_q <= i_cfg;
		end
	end

	row_writer #(
		.BUF_ROWS(BUF_ROWS)
	) u_row_writer (
		.clk            (clk),
		.rst            (rst),
		.i_start        (i_start),
		.i_cfg          (cfg_q),
		.i_valid        (i_valid),
		.i_pix          (i_pix),
		.i_rows_released(rows_released),
		.o_wr           (wr),
		.o_rows_written (rows_written),
		.o_full         (o_full)
	);

	window_reader #(
		.BUF_ROWS(BUF_ROWS)
	) u_window_reader (
		.clk            (clk),
		.rst            (rst),
		.i_start        (i_start),
		.i_cfg          (cfg_q),
		.i_rows_written (rows_written),
		.o_rows_released(rows_released),
		.o_rd           (rd)
	);

	line_ram #(
		.DEPTH(DEPTH)
	) u_line_ram (
		.clk      (clk),
		.i_wr     (wr),
		.i_rd_addr(rd.addr),
		.o_rd_data(rd_data)
	);

	pixel_output u_pixel_output (
		.clk      (clk),
		.rst      (rst),
		.i_rd     (rd),
		.i_rd_data(rd_data),
		.o_valid  (o_valid),
		.o_pix    (o_pix),
		.o_done   (o_done)
	);

endmodule

// ==== test/feeder_top_sva.sv ====
module feeder_top_sva (
	input logic clk,
	input logic rst,
	input logic i_start,
	input logic o_valid,
	input logic o_done
);
	logic started;   // a frame has begun since reset

	always_ff @(posedge clk) begin
		if (rst) begin
			started <= 1'b0;
		end else if (i_start) begin
			started <= 1'b1;
		end
	end

	quiet_after_reset: assert property (@(posedge clk) rst |=> (!o_valid && !o_done))
		else $error("o_valid or o_done high right after reset");

	done_with_valid: assert property (@(posedge clk) disable iff (rst) o_done |-> o_valid)
		else $error("o_done high without o_valid");

	no_early_output: assert property (@(posedge clk) disable iff (rst) !started |-> !o_valid)
		else $error("o_valid before any frame was started");

endmodule

bind feeder_top feeder_top_sva u_feeder_top_sva (
	.clk    (clk),
	.rst    (rst),
	.i_start(i_start),
	.o_valid(o_valid),
	.o_done (o_done)
);

// ==== test/feeder_top_tb.sv ====
module feeder_top_tb;
	import feeder_pkg::*;

	localparam int SEED      = 53;
	localparam int N_FRAMES  = 9;
	localparam int IMG_WORDS = MAX_COLS * MAX_COLS * MAX_CHANS;

	logic     clk = 1'b0;
	logic     rst;
	logic     i_start;
	cfg_t     i_cfg;
	logic     i_valid;
	pix_in_t  i_pix;
	logic     o_full;
	logic     o_valid;
	pix_out_t o_pix;
	logic     o_done;

	logic [31:0]       rng = SEED;
	logic [DATA_W-1:0] image [IMG_WORDS];   // (row * cols + col) * chans + chan
	pix_out_t          exp_q [$];
	cfg_t              frames [N_FRAMES];
	int                errors = 0;
	int                frame_errs = 0;
	int                tests = 0;
	int                failed = 0;
	int                pad_seen;
	int                pad_exp;
	int                done_seen;
	int                stalls;
	int                cycle_cnt = 0;
	int                timeout_cycles = 200;
	logic              limit_set = 1'b0;

	always #4 clk = ~clk;

	feeder_top #(
		.BUF_ROWS(4)
	) u_feeder_top (
		.clk    (clk),
		.rst    (rst),
		.i_start(i_start),
		.i_cfg  (i_cfg),
		.i_valid(i_valid),
		.i_pix  (i_pix),
		.o_full (o_full),
		.o_valid(o_valid),
		.o_pix  (o_pix),
		.o_done (o_done)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_rand(input int unsigned range, output int unsigned r);
		rng = xorshift32(rng);
		r = rng % range;
	endtask

	function automatic int frame_cycles(input cfg_t cfg);
		int n;
		int c;
		int od;
		n = int'(cfg.cols);
		c = int'(cfg.chans);
		od = (n - 1) / (cfg.stride2 ? 2 : 1) + 1;
		return 4 * (n * n * c + od * od * 9 * c);
	endfunction

	task automatic compare_pix(input pix_out_t got, input pix_out_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: o_pix got data=%h pad=%b, expected data=%h pad=%b",
				$time, got.data, got.pad, exp.data, exp.pad);
			frame_errs++;
		end
	endtask

	task automatic compare_done(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: o_done got %b, expected %b", $time, got, exp);
			frame_errs++;
		end
	endtask

	task automatic compare_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
			frame_errs++;
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
			frame_errs++;
		end
	endtask

	// expected stream: oy, ox, then ky, kx, then channel
	task automatic build_expected(input cfg_t cfg);
		int n;
		int nc;
		int step;
		int od;
		int sr;
		int sc;
		pix_out_t w;
		n = int'(cfg.cols);
		nc = int'(cfg.chans);
		step = cfg.stride2 ? 2 : 1;
		od = (n - 1) / step + 1;
		exp_q.delete();
		pad_exp = 0;
		for (int oy = 0; oy < od; oy++)
			for (int ox = 0; ox < od; ox++)
				for (int k = 0; k < 9; k++)
					for (int ch = 0; ch < nc; ch++) begin
						sr = oy * step + k / 3 - 1;
						sc = ox * step + k % 3 - 1;
						if (sr < 0 || sr >= n || sc < 0 || sc >= n) begin
							w.data = '0;
							w.pad  = 1'b1;
							pad_exp++;
						end else begin
							w.data = image[(sr * n + sc) * nc + ch];
							w.pad  = 1'b0;
						end
						exp_q.push_back(w);
					end
	endtask

	task automatic new_image(input cfg_t cfg);
		int unsigned r;
		for (int i = 0; i < int'(cfg.cols) * int'(cfg.cols) * int'(cfg.chans); i++) begin
			next_rand(1 << DATA_W, r);
			image[i] = r[DATA_W-1:0];
		end
		build_expected(cfg);
		frame_errs = 0;
		pad_seen = 0;
		done_seen = 0;
		stalls = 0;
	endtask

	task automatic start_frame(input cfg_t cfg);
		i_cfg   <= cfg;
		i_start <= 1'b1;
		@(posedge clk);
		i_start <= 1'b0;
		@(posedge clk);   // writer loads its row size here
	endtask

	// a stalled word is held, otherwise a random gap may follow
	task automatic feed_words(input int words, input int gap);
		int idx;
		int unsigned r;
		logic stall;
		idx = 0;
		stall = 1'b0;
		while (idx < words) begin
			if (!stall) begin
				next_rand(8, r);
				i_valid    <= (r >= gap);
				i_pix.data <= image[idx];
			end
			@(negedge clk);
			stall = i_valid && o_full;
			if (stall) stalls++;
			if (i_valid && !o_full) idx++;
			@(posedge clk);
		end
		i_valid <= 1'b0;
	endtask

	task automatic report_test(input string name, input cfg_t cfg);
		tests++;
		errors += frame_errs;
		if (frame_errs != 0) failed++;
		$display("%s (cols %0d, chans %0d, stride %0d): %s", name, cfg.cols, cfg.chans,
			cfg.stride2 ? 2 : 1, (frame_errs == 0) ? "pass" : "fail");
	endtask

	task automatic run_frame(input string name, input cfg_t cfg, input int gap,
		input logic need_stall);
		new_image(cfg);
		start_frame(cfg);
		feed_words(int'(cfg.cols) * int'(cfg.cols) * int'(cfg.chans), gap);
		while (done_seen == 0) @(posedge clk);
		repeat (20) @(posedge clk);   // window for stray words after done
		compare_count("padded words", pad_seen, pad_exp);
		compare_count("done pulses", done_seen, 1);
		compare_count("missing words", exp_q.size(), 0);
		if (need_stall && stalls == 0) begin
			$display("ERROR: o_full never held back an input word");
			frame_errs++;
		end
		report_test(name, cfg);
	endtask

	task automatic reset_mid_frame(input cfg_t cfg);
		new_image(cfg);
		start_frame(cfg);
		feed_words(int'(cfg.cols) * int'(cfg.cols) * int'(cfg.chans) / 2, 2);
		rst <= 1'b1;
		exp_q.delete();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		compare_level("o_full", o_full, 1'b0);
		compare_level("o_valid", o_valid, 1'b0);
		compare_level("o_done", o_done, 1'b0);
		@(posedge clk);
		report_test("reset mid-frame", cfg);
	endtask

	always @(negedge clk) begin
		if (!rst) begin
			if (o_done && !o_valid) begin
				$display("ERROR at %0t: o_done high without o_valid", $time);
				frame_errs++;
			end
			if (o_valid) begin
				if (exp_q.size() == 0) begin
					$display("ERROR at %0t: output word with none expected", $time);
					frame_errs++;
				end else begin
					compare_pix(o_pix, exp_q[0]);
					compare_done(o_done, exp_q.size() == 1);
					void'(exp_q.pop_front());
				end
				if (o_pix.pad) pad_seen++;
				if (o_done) done_seen++;
			end
		end
	end

	initial begin
		wait (limit_set);
		while (cycle_cnt < timeout_cycles) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("ERROR: run timed out after %0d cycles", cycle_cnt);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int unsigned r;
		rst     = 1'b1;
		i_start = 1'b0;
		i_cfg   = '0;
		i_valid = 1'b0;
		i_pix   = '0;
		// frames 0-2 stride 1, 3-5 stride 2, 6 fills the ring, 7-8 reset pair
		for (int i = 0; i < N_FRAMES; i++) begin
			next_rand(10, r);
			frames[i].cols = (i == 6) ? COL_W'(8 + r / 2) : COL_W'(3 + r);
			next_rand(4, r);
			frames[i].chans = CHAN_W'(1 + r);
			next_rand(2, r);
			frames[i].stride2 = (i < 3) ? 1'b0 : (i < 6) ? 1'b1 : r[0];
			timeout_cycles += frame_cycles(frames[i]);
		end
		limit_set = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		for (int i = 0; i < 3; i++) run_frame("stride 1", frames[i], 2, 1'b0);
		for (int i = 3; i < 6; i++) run_frame("stride 2", frames[i], 2, 1'b0);
		run_frame("back-pressure", frames[6], 0, 1'b1);
		reset_mid_frame(frames[7]);
		run_frame("after reset", frames[8], 3, 1'b0);
		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== feeder_top.f ====
verilog/feeder_pkg.sv
verilog/line_ram.sv
verilog/row_writer.sv
verilog/window_reader.sv
verilog/pixel_output.sv
verilog/feeder_top.sv
test/feeder_top_sva.sv
test/feeder_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the feeder testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module feeder_top_tb \
	-Mdir obj_dir -f feeder_top.f
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/Vfeeder_top_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi
exit 0
